/* rtl/zclk_types_pkg.sv */
/*
 * Z80 clock-side types
 * turbo mode codes, the fclk phase position and the edge count width
 * shared by the clock generator stages and the testbench checks
 */

package zclk_types_pkg;

	// requested or active Z80 clock rate
	// 2'b00 is 3.5 MHz
	// 2'b01 is 7 MHz
	// 2'b1x is 14 MHz, bit 1 alone decides it
	typedef logic [1:0] turbo_t;

	// position inside the four-cycle fclk phase
	// phase 0 carries c0, phase 2 carries c2
	typedef logic [1:0] phase_t;

	// zpos or zneg edge count over a test window
	typedef logic [15:0] zcount_t;

endpackage

/* rtl/zbus_pkg.sv */
/*
 * Z80 bus-side types
 * I/O wait counter, memory stall FSM states and the I/O wait length
 */

package zbus_pkg;

	// fclk cycles of stall for one external I/O access at 14 MHz
	// half as many zpos pulses are lost
	localparam int IO_WAIT_CYCLES = 12;

	// remaining cycles of the I/O wait
	typedef logic [3:0] iowait_t;

	// memory stall handshake toward the arbiter
	// S_IDLE     no request, mem_ack is known low
	// S_REQ      mem_req high, Z80 clock held
	// S_RELEASE  mem_req low, waiting for mem_ack to drop
	typedef enum logic [1:0]
	{
		S_IDLE,
		S_REQ,
		S_RELEASE
	} stall_state_t;

endpackage

/* rtl/zstrobe_if.sv */
/*
 * Inter-stage links of the Z80 clock generator
 * zstrobe_if carries fclk phase strobes, the active turbo and zpos feedback
 * zstall_if carries the wait-state flags into the edge stage
 */

interface zstrobe_if;
	import zclk_types_pkg::*;

	// one-cycle strobes in phase 0 and phase 2
	logic c0;
	logic c2;
	// toggles on every c2, splits c2 into two alternating halves
	logic c2_half;
	// turbo mode latched at refresh
	turbo_t int_turbo;
	// registered zpos from the edge stage
	logic zpos_fb;

	modport phase_src (output c0, c2, c2_half, int_turbo, input zpos_fb);
	modport stall_sink (input int_turbo, zpos_fb);
	modport edge_sink (input c0, c2, c2_half, int_turbo, output zpos_fb);
endinterface

interface zstall_if;
	// any wait state holding the Z80 clock
	logic stall;
	logic io_wait;
	logic mem_wait;
	// active mode is 14 MHz
	logic int_turbo_14;

	modport source (output stall, io_wait, mem_wait, int_turbo_14);
	modport sink (input stall, io_wait, mem_wait, int_turbo_14);
endinterface

/* rtl/zturbo_phase.sv */
/*
 * Phase and turbo stage
 * free-running fclk phase counter with the c0, c2 and half-c2 strobes,
 * and the refresh edge detector that switches the active turbo mode
 */

module zturbo_phase
(
	input  logic                  fclk,
	input  logic                  rst,
	input  zclk_types_pkg::turbo_t turbo,
	input  logic                  rfsh_n,
	zstrobe_if.phase_src          strobes
);
	import zclk_types_pkg::*;

	phase_t phase;
	logic   c2_half;
	// rfsh_n as sampled at the previous zpos
	logic   rfsh_n_old;

	// four fclk cycles per phase round
	always_ff @(posedge fclk)
	begin
		if (rst)
			phase <= '0;
		else
			phase <= phase + phase_t'(1);
	end

	assign strobes.c0 = (phase == phase_t'(0));
	assign strobes.c2 = (phase == phase_t'(2));

	// every other c2, gives the 3.5 MHz spacing
	always_ff @(posedge fclk)
	begin
		if (rst)
			c2_half <= 1'b0;
		else if (strobes.c2)
			c2_half <= ~c2_half;
	end

	assign strobes.c2_half = c2_half;

	// rfsh_n sampled only at zpos
	// new turbo taken on the first low sample after a high one
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			rfsh_n_old        <= 1'b1;
			strobes.int_turbo <= '0;
		end
		else if (strobes.zpos_fb)
		begin
			rfsh_n_old <= rfsh_n;
			if (rfsh_n_old && !rfsh_n)
				strobes.int_turbo <= turbo;
		end
	end

	// mode switch lands only right after a Z80 rising edge
	a_turbo_at_zpos: assert property (
		@(posedge fclk) disable iff (rst)
		$changed(strobes.int_turbo) |-> $past(strobes.zpos_fb)
	);

endmodule

/* rtl/zstall_ctrl.sv */
/*
 * Stall stage
 * 14 MHz wait states: a fixed stall for external I/O accesses and
 * a four-phase mem_req/mem_ack stall for memory accesses
 */

module zstall_ctrl
#(
	parameter int IO_WAIT_EN = 1
)
(
	input  logic          fclk,
	input  logic          rst,
	input  logic          iorq,
	input  logic          external_port,
	input  logic          mreq,
	output logic          mem_req,
	input  logic          mem_ack,
	zstrobe_if.stall_sink strobes,
	zstall_if.source      stall
);
	import zbus_pkg::*;

	logic         turbo14;
	logic         io;
	logic         io_r;
	logic         mreq_r;
	logic         io_trig;
	logic         mem_trig;
	iowait_t      io_cnt;
	stall_state_t state;
	// access seen while the arbiter still holds mem_ack
	logic         mem_pend;

	assign turbo14 = strobes.int_turbo[1];
	assign io      = iorq & external_port;

	// bus strobes sampled at zpos, as the Z80 sees them
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			io_r   <= 1'b0;
			mreq_r <= 1'b0;
		end
		else if (strobes.zpos_fb)
		begin
			io_r   <= io;
			mreq_r <= mreq;
		end
	end

	// rising edges at zpos, 14 MHz only
	assign io_trig  = (IO_WAIT_EN != 0) && io && !io_r && strobes.zpos_fb && turbo14;
	assign mem_trig = mreq && !mreq_r && strobes.zpos_fb && turbo14;

	// I/O wait countdown, high from the next cycle for IO_WAIT_CYCLES
	always_ff @(posedge fclk)
	begin
		if (rst)
			io_cnt <= '0;
		else if (io_trig)
			io_cnt <= iowait_t'(IO_WAIT_CYCLES);
		else if (!turbo14)
			io_cnt <= '0;
		else if (io_cnt != '0)
			io_cnt <= io_cnt - iowait_t'(1);
	end

	// memory handshake, new request only once mem_ack is low again
	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			state    <= S_IDLE;
			mem_pend <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (mem_trig)
						state <= S_REQ;
				S_REQ:
					if (mem_ack)
						state <= S_RELEASE;
				S_RELEASE:
					if (!mem_ack)
					begin
						mem_pend <= 1'b0;
						state    <= (mem_trig || mem_pend) ? S_REQ : S_IDLE;
					end
					else if (mem_trig)
						mem_pend <= 1'b1;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	assign mem_req = (state == S_REQ);

	// a slow ack release only stretches the stall through mem_pend
	assign stall.io_wait      = turbo14 && (io_cnt != '0);
	assign stall.mem_wait     = turbo14 && (mem_req || mem_pend);
	assign stall.stall        = stall.io_wait || stall.mem_wait;
	assign stall.int_turbo_14 = turbo14;

	a_req_after_ack_low: assert property (
		@(posedge fclk) disable iff (rst)
		$rose(mem_req) |-> !mem_ack
	);

	// the wait sources themselves only ever run at 14 MHz
	a_stall_only_14: assert property (
		@(posedge fclk) disable iff (rst)
		((io_cnt != '0) || mem_req) |-> strobes.int_turbo[1]
	);

endmodule

/* rtl/zedge_gen.sv */
/*
 * Edge stage
 * selects the pre-edge pair for the active turbo mode and registers
 * zpos, zneg and the Z80 clock, all held while a wait state is on
 */

module zedge_gen
(
	input  logic         fclk,
	input  logic         rst,
	zstrobe_if.edge_sink strobes,
	zstall_if.sink       stall,
	output logic         zpos,
	output logic         zneg,
	output logic         zclk_out
);

	// 14 MHz source, frozen during stall so the pattern resumes in step
	logic clk14_src;
	logic pre_zpos;
	logic pre_zneg;
	// Z80 clock level after this cycle's edge has been applied
	logic zclk_nxt;

	always_ff @(posedge fclk)
	begin
		if (rst)
			clk14_src <= 1'b0;
		else if (!stall.stall)
			clk14_src <= ~clk14_src;
	end

	always_comb
	begin
		if (stall.int_turbo_14)
		begin
			pre_zpos = clk14_src;
			pre_zneg = ~clk14_src;
		end
		else if (strobes.int_turbo[0])
		begin
			// 7 MHz, zpos lands in phase 3 and zneg in phase 1
			pre_zpos = strobes.c2;
			pre_zneg = strobes.c0;
		end
		else
		begin
			// 3.5 MHz, c2 alternates between zpos and zneg
			pre_zpos = strobes.c2 & ~strobes.c2_half;
			pre_zneg = strobes.c2 & strobes.c2_half;
		end
	end

	// zpos drops the clock, zneg raises it
	// using the updated level keeps the 14 MHz edges one fclk apart
	assign zclk_nxt = zpos ? 1'b0 : (zneg ? 1'b1 : zclk_out);

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			zpos     <= 1'b0;
			zneg     <= 1'b0;
			zclk_out <= 1'b0;
		end
		else
		begin
			zpos     <= ~stall.stall & pre_zpos & zclk_nxt;
			zneg     <= ~stall.stall & pre_zneg & ~zclk_nxt;
			// output inverted externally
			zclk_out <= zclk_nxt;
		end
	end

	assign strobes.zpos_fb = zpos;

	a_zpos_zneg_excl: assert property (
		@(posedge fclk) disable iff (rst)
		!(zpos && zneg)
	);

	// one bus cycle at a time, so I/O and memory waits never overlap
	a_single_wait: assert property (
		@(posedge fclk) disable iff (rst)
		!(stall.io_wait && stall.mem_wait)
	);

endmodule

/* rtl/zclock_top.sv */
/*
 * Z80 clock generator
 * phase and turbo stage, stall stage and edge stage in a row,
 * producing zclk_out, zpos and zneg at 3.5, 7 or 14 MHz from fclk
 */

module zclock_top
#(
	parameter int IO_WAIT_EN = 1
)
(
	input  logic                   fclk,
	input  logic                   rst,
	input  zclk_types_pkg::turbo_t turbo,
	input  logic                   rfsh_n,
	input  logic                   iorq,
	input  logic                   external_port,
	input  logic                   mreq,
	output logic                   mem_req,
	input  logic                   mem_ack,
	output logic                   zclk_out,
	output logic                   zpos,
	output logic                   zneg,
	output zclk_types_pkg::turbo_t int_turbo
);

	zstrobe_if strobes_if ();
	zstall_if  stall_if ();

	// phase strobes and turbo latch
	zturbo_phase u_turbo_phase (
		.fclk    (fclk),
		.rst     (rst),
		.turbo   (turbo),
		.rfsh_n  (rfsh_n),
		.strobes (strobes_if.phase_src)
	);

	// 14 MHz wait states and arbiter handshake
	zstall_ctrl #(
		.IO_WAIT_EN (IO_WAIT_EN)
	) u_stall_ctrl (
		.fclk          (fclk),
		.rst           (rst),
		.iorq          (iorq),
		.external_port (external_port),
		.mreq          (mreq),
		.mem_req       (mem_req),
		.mem_ack       (mem_ack),
		.strobes       (strobes_if.stall_sink),
		.stall         (stall_if.source)
	);

	// Z80 clock edges
	zedge_gen u_edge_gen (
		.fclk     (fclk),
		.rst      (rst),
		.strobes  (strobes_if.edge_sink),
		.stall    (stall_if.sink),
		.zpos     (zpos),
		.zneg     (zneg),
		.zclk_out (zclk_out)
	);

	assign int_turbo = strobes_if.int_turbo;

endmodule

/* bench/zclock_tb.sv */
/*
 * Z80 clock generator testbench
 * runs the tests listed in the data file against zclock_top, plays the
 * memory arbiter and checks zpos counts, the turbo latch and mem handshake
 */

module zclock_tb;
	import zclk_types_pkg::*;
	import zbus_pkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int RFSH_CYCLES   = 10;
	localparam int SETTLE_CYCLES = 32;
	localparam int ACCESS_CYCLES = 4;
	localparam int GAP_CYCLES    = 16;
	// access kinds of the data file
	localparam int KIND_IO_EXT   = 1;
	localparam int KIND_IO_INT   = 2;
	localparam int KIND_MEM      = 3;

	logic    fclk;
	logic    rst;
	turbo_t  turbo;
	logic    rfsh_n;
	logic    iorq;
	logic    external_port;
	logic    mreq;
	logic    mem_req;
	logic    mem_ack;
	logic    zclk_out;
	logic    zpos;
	logic    zneg;
	turbo_t  int_turbo;

	// test table, one entry per data line
	string   names[$];
	int      t_turbo[$];
	int      t_rfsh[$];
	int      t_kind[$];
	int      t_window[$];
	int      t_count[$];
	int      t_exp[$];

	string   cur_name;
	logic    count_en;
	zcount_t zpos_count;
	// expected Z80 clock level in the current cycle
	logic    zclk_exp;
	logic    req_q;
	logic    ack_q;
	logic    req_seen;
	int      handshakes;
	int      ack_delay;
	int      value_errors;
	int      other_errors;
	int      cycle_count;
	int      cycle_limit;

	zclock_top #(
		.IO_WAIT_EN (1)
	) UUT (
		.fclk          (fclk),
		.rst           (rst),
		.turbo         (turbo),
		.rfsh_n        (rfsh_n),
		.iorq          (iorq),
		.external_port (external_port),
		.mreq          (mreq),
		.mem_req       (mem_req),
		.mem_ack       (mem_ack),
		.zclk_out      (zclk_out),
		.zpos          (zpos),
		.zneg          (zneg),
		.int_turbo     (int_turbo)
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	always @(posedge fclk)
		cycle_count <= cycle_count + 1;

	// arbiter model, answers each mem_req after 1 to 20 cycles
	initial
	begin : arbiter
		// fixed seed, the ack delays repeat from run to run
		void'($urandom(32'hd975_d776));
		mem_ack = 1'b0;
		forever
		begin
			@(posedge fclk);
			#1;
			if (mem_req && !mem_ack)
			begin
				ack_delay = $urandom_range(20, 1);
				repeat (ack_delay) @(posedge fclk);
				#1;
				mem_ack = 1'b1;
			end
			else if (!mem_req && mem_ack)
				mem_ack = 1'b0;
		end
	end

	task automatic flag_violation(input string what);
		$display("%s at cycle %0d", what, cycle_count);
		other_errors++;
	endtask

	// outputs sampled mid-cycle, inputs move 1 unit after the rising edge
	always @(negedge fclk)
	begin
		if (!rst)
		begin
			if (count_en && zpos)
				zpos_count = zpos_count + zcount_t'(1);
			if (zpos && zneg)
				flag_violation("zpos and zneg were high in the same cycle");
			// Z80 clock falls after zpos and rises after zneg
			check_bit(cur_name, "zclk_out", zclk_exp, zclk_out);
			if (zpos)
				zclk_exp = 1'b0;
			else if (zneg)
				zclk_exp = 1'b1;
			// four-phase order of mem_req against mem_ack
			if (mem_req && !req_q && (mem_ack || ack_q))
				flag_violation("mem_req rose before mem_ack had fallen");
			if (!mem_req && req_q && !ack_q)
				flag_violation("mem_req fell before mem_ack was raised");
			if (mem_req && zpos)
				flag_violation("zpos pulsed while mem_req waited for mem_ack");
			if (mem_req)
				req_seen = 1'b1;
			if (!mem_ack && ack_q)
				handshakes++;
			req_q = mem_req;
			ack_q = mem_ack;
		end
	end

	task automatic next_cycle();
		@(posedge fclk);
		#1;
	endtask

	task automatic check_turbo(input string name, input turbo_t expected, input turbo_t actual);
		if (actual !== expected)
		begin
			$display("Error %s: int_turbo expected %b, actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input zcount_t expected, input zcount_t actual);
		if (actual !== expected)
		begin
			$display("Error %s: zpos count expected %0d, actual %0d", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_count_range(input string name, input zcount_t lo, input zcount_t hi,
		input zcount_t actual);
		if (actual < lo || actual > hi)
		begin
			$display("Error %s: zpos count expected %0d to %0d, actual %0d", name, lo, hi, actual);
			value_errors++;
		end
	endtask

	task automatic check_bit(input string name, input string what, input logic expected,
		input logic actual);
		if (actual !== expected)
		begin
			$display("Error %s %s: expected %b, actual %b", name, what, expected, actual);
			value_errors++;
		end
	endtask

	task automatic load_tests();
		int    fd;
		int    n;
		string line;
		string name;
		int    f_turbo;
		int    f_rfsh;
		int    f_kind;
		int    f_window;
		int    f_count;
		int    f_exp;
		fd = $fopen("bench/zclock_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("test data file bench/zclock_testdata.txt could not be opened");
			other_errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// comment and blank lines hold no test
			if (line.len() > 0 && line.getc(0) != "#")
			begin
				n = $sscanf(line, "%s %h %d %d %d %d %h", name, f_turbo, f_rfsh, f_kind,
					f_window, f_count, f_exp);
				if (n == 7)
				begin
					names.push_back(name);
					t_turbo.push_back(f_turbo);
					t_rfsh.push_back(f_rfsh);
					t_kind.push_back(f_kind);
					t_window.push_back(f_window);
					t_count.push_back(f_count);
					t_exp.push_back(f_exp);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int idx);
		string   name;
		turbo_t  exp_turbo;
		zcount_t base;
		zcount_t lo;
		zcount_t hi;
		int      kind;
		int      hs_start;
		name      = names[idx];
		cur_name  = name;
		exp_turbo = turbo_t'(t_exp[idx]);
		base      = zcount_t'(t_count[idx]);
		kind      = t_kind[idx];
		turbo     = turbo_t'(t_turbo[idx]);
		if (t_rfsh[idx] != 0)
		begin
			// low long enough for a 3.5 MHz zpos to sample it
			rfsh_n = 1'b0;
			repeat (RFSH_CYCLES) next_cycle();
			rfsh_n = 1'b1;
		end
		repeat (SETTLE_CYCLES) next_cycle();
		check_turbo(name, exp_turbo, int_turbo);
		zpos_count = '0;
		req_seen   = 1'b0;
		hs_start   = handshakes;
		count_en   = 1'b1;
		if (kind == KIND_IO_EXT || kind == KIND_IO_INT)
		begin
			iorq          = 1'b1;
			external_port = (kind == KIND_IO_EXT);
		end
		else if (kind == KIND_MEM)
			mreq = 1'b1;
		// the access is seen at the first zpos of the window
		repeat (ACCESS_CYCLES) next_cycle();
		iorq          = 1'b0;
		external_port = 1'b0;
		mreq          = 1'b0;
		repeat (t_window[idx] - ACCESS_CYCLES) next_cycle();
		count_en = 1'b0;
		if (kind == KIND_IO_EXT && exp_turbo[1])
			check_count(name, base - zcount_t'(IO_WAIT_CYCLES / 2), zpos_count);
		else if (kind == KIND_MEM && exp_turbo[1])
		begin
			// stall of ack_delay + 1 cycles delays the zpos train by as much
			// odd stall lengths leave the count one off either way
			lo = base - zcount_t'((ack_delay + 2) / 2);
			hi = base - zcount_t'((ack_delay + 1) / 2);
			check_count_range(name, lo, hi, zpos_count);
			check_bit(name, "mem handshake", 1'b1, (handshakes - hs_start) == 1);
		end
		else
		begin
			check_count(name, base, zpos_count);
			if (kind == KIND_MEM)
				check_bit(name, "mem_req raised", 1'b0, req_seen);
		end
		check_bit(name, "mem_req at end", 1'b0, mem_req);
		repeat (GAP_CYCLES) next_cycle();
	endtask

	task automatic print_error_counts();
		$display("%0d value errors, %0d other errors", value_errors, other_errors);
	endtask

	// run ends here if a test hangs
	initial
	begin : watchdog
		wait (cycle_limit != 0);
		wait (cycle_count >= cycle_limit);
		$display("cycle limit of %0d reached before the tests finished", cycle_limit);
		other_errors++;
		print_error_counts();
		$display("tests failed");
		$finish;
	end

	initial
	begin
		rst           = 1'b1;
		turbo         = '0;
		rfsh_n        = 1'b1;
		iorq          = 1'b0;
		external_port = 1'b0;
		mreq          = 1'b0;
		cur_name      = "reset";
		count_en      = 1'b0;
		zpos_count    = '0;
		zclk_exp      = 1'b0;
		req_q         = 1'b0;
		ack_q         = 1'b0;
		req_seen      = 1'b0;
		load_tests();
		// windows plus the fixed steps of each test, memory tests get 200 extra
		cycle_limit = RESET_CYCLES + SETTLE_CYCLES;
		foreach (t_window[i])
			cycle_limit += t_window[i] + RFSH_CYCLES + SETTLE_CYCLES + GAP_CYCLES
				+ ((t_kind[i] == KIND_MEM) ? 200 : 0);
		repeat (RESET_CYCLES) next_cycle();
		rst = 1'b0;
		repeat (8) next_cycle();
		foreach (names[i])
			run_test(i);
		print_error_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* bench/zclock_testdata.txt */
# name  turbo(hex)  rfsh_pulse  kind  window  zpos_count  int_turbo(hex)
# kind 0 none, 1 io on external port, 2 io on internal port, 3 mem
# zpos_count is the count of the window without any wait state
reset_35        0 0 0 64  8 0
turbo_held_35   1 0 0 64  8 0
rfsh_to_7       1 1 0 64 16 1
io_ext_7        1 0 1 64 16 1
io_int_7        1 0 2 64 16 1
mem_7           1 0 3 64 16 1
rfsh_to_14      2 1 0 64 32 2
io_ext_14       2 0 1 64 32 2
io_int_14       2 0 2 64 32 2
mem_14_a        2 0 3 96 48 2
mem_14_b        2 0 3 96 48 2
mem_14_c        2 0 3 96 48 2
mem_14_d        2 0 3 96 48 2
mem_14_e        2 0 3 96 48 2
mem_14_f        2 0 3 96 48 2
io_ext_14_b     2 0 1 80 40 2
turbo3_held     3 0 0 64 32 2
rfsh_to_14_b    3 1 0 64 32 3
io_ext_14_c     3 0 1 64 32 3
mem_14_g        3 0 3 96 48 3
mem_14_h        3 0 3 96 48 3
turbo0_held     0 0 0 64 32 3
rfsh_to_35      0 1 0 64  8 0
io_ext_35       0 0 1 64  8 0
io_int_35       0 0 2 64  8 0
mem_35          0 0 3 64  8 0
mem_35_b        0 0 3 96 12 0

/* vlog.f */
rtl/zclk_types_pkg.sv
rtl/zbus_pkg.sv
rtl/zstrobe_if.sv
rtl/zturbo_phase.sv
rtl/zstall_ctrl.sv
rtl/zedge_gen.sv
rtl/zclock_top.sv
bench/zclock_tb.sv
